// File: sms_defs.svh
`ifndef SMS_DEFS_SVH
`define SMS_DEFS_SVH

// ============================================================
// VDP register file
// ============================================================

// Registers 0 to 10 are writable through the control port
`define SMS_VDP_REG_COUNT 11

// ============================================================
// Memory control and mapper
// ============================================================

// BIOS enabled, cartridge and card slots disabled
`define SMS_MEM_CTRL_RESET 8'hF7

// Banks seen in pages 0, 1 and 2 after reset
`define SMS_SLOT0_RESET 8'h00
`define SMS_SLOT1_RESET 8'h01
`define SMS_SLOT2_RESET 8'h02

// Mapper registers sit in the top four bytes of RAM space
`define SMS_MAP_MISC_ADDR  16'hFFFC
`define SMS_MAP_SLOT0_ADDR 16'hFFFD
`define SMS_MAP_SLOT1_ADDR 16'hFFFE
`define SMS_MAP_SLOT2_ADDR 16'hFFFF

// Second joypad port with nothing plugged in
`define SMS_JOY1_IDLE 8'hBF

`endif

// File: sms_bus_pkg.sv
`default_nettype none

package sms_bus_pkg;

  // Z80 side of the bus
  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  cpu_byte_t;

  // Bank number above the 14-bit page offset, zero-extended
  typedef logic [23:0] rom_addr_t;

  // Port select is {A7, A6, A0}
  typedef enum logic [2:0] {
    PORT_MEM_CTRL      = 3'd0,
    PORT_JOY_CTRL      = 3'd1,
    PORT_V_COUNTER     = 3'd2,
    // Writes go to the PSG, reads return the H counter
    PORT_PSG_H_COUNTER = 3'd3,
    PORT_VDP_DATA      = 3'd4,
    PORT_VDP_CTRL      = 3'd5,
    PORT_JOY_A         = 3'd6,
    PORT_JOY_B         = 3'd7
  } io_port_e;

  // Buttons, bit 0 not connected
  typedef logic [6:0] pad_buttons_t;

endpackage

`default_nettype wire

// File: sms_vdp_pkg.sv
`default_nettype none

package sms_vdp_pkg;

  // ============================================================
  // Addresses
  // ============================================================

  // 16 KB of VRAM, also used as the CRAM pointer
  typedef logic [13:0] vram_addr_t;

  // ============================================================
  // Registers and modes
  // ============================================================

  // Index carried in the low nibble of the second control byte
  typedef logic [3:0] vdp_reg_idx_t;

  // TMS9918 modes 0 to 3 plus the SMS mode 4
  typedef enum logic [2:0] {
    VDP_MODE_0 = 3'd0,
    VDP_MODE_1 = 3'd1,
    VDP_MODE_2 = 3'd2,
    VDP_MODE_3 = 3'd3,
    VDP_MODE_4 = 3'd4
  } vdp_mode_e;

  // ============================================================
  // Status
  // ============================================================

  // Number of the sprite that overflowed a line
  typedef logic [4:0] sprite_x_t;

endpackage

`default_nettype wire

// File: sms_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sms_bus_decode
  import sms_bus_pkg::*;
(
  input  wire cpu_addr_t i_cpu_addr,
  input  wire logic      i_n_rd,
  input  wire logic      i_n_wr,
  input  wire logic      i_n_mreq,
  input  wire logic      i_n_iorq,
  output io_port_e       o_io_rd_port,
  output logic           o_io_rd_valid,
  output logic           o_vdp_data_rd,
  output logic           o_vdp_data_wr,
  output logic           o_vdp_ctrl_rd,
  output logic           o_vdp_ctrl_wr,
  output logic           o_mem_ctrl_wr,
  output logic           o_mem_wr,
  output logic           o_mem_rd
);

  logic     io_rd;
  logic     io_wr;
  io_port_e port;

  // I/O and memory cycles from the raw strobes
  assign io_rd = !i_n_iorq && !i_n_rd;
  assign io_wr = !i_n_iorq && !i_n_wr;

  assign o_mem_rd = !i_n_mreq && !i_n_rd;
  assign o_mem_wr = !i_n_mreq && !i_n_wr;

  // Only A7, A6 and A0 take part in the port decode
  assign port = io_port_e'({i_cpu_addr[7:6], i_cpu_addr[0]});

  assign o_io_rd_port  = port;
  assign o_io_rd_valid = io_rd;

  // One level per port action
  assign o_vdp_data_rd = io_rd && (port == PORT_VDP_DATA);
  assign o_vdp_data_wr = io_wr && (port == PORT_VDP_DATA);
  assign o_vdp_ctrl_rd = io_rd && (port == PORT_VDP_CTRL);
  assign o_vdp_ctrl_wr = io_wr && (port == PORT_VDP_CTRL);
  assign o_mem_ctrl_wr = io_wr && (port == PORT_MEM_CTRL);

  // ============================================================
  // Bus protocol check
  // ============================================================

  // Sampled as IORQ rises, so the values are those of the ending cycle
  a_no_io_rd_wr_overlap : assert property (
    @(posedge i_n_iorq) !(o_io_rd_valid === 1'b1 && io_wr === 1'b1)
  ) else $error("I/O read and write active in the same cycle");

endmodule

`default_nettype wire

// File: sms_vdp_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "sms_defs.svh"

module sms_vdp_port
  import sms_bus_pkg::*;
  import sms_vdp_pkg::*;
(
  input  wire logic       cpuClock,
  input  wire logic       n_hard_reset,
  input  wire logic       i_cpu_ce,
  input  wire cpu_byte_t  i_cpu_dout,
  input  wire logic       i_vdp_data_rd,
  input  wire logic       i_vdp_data_wr,
  input  wire logic       i_vdp_ctrl_rd,
  input  wire logic       i_vdp_ctrl_wr,
  input  wire logic       i_vdp_irq_flag,
  input  wire logic       i_sprite_collision,
  input  wire logic       i_too_many_sprites,
  input  wire sprite_x_t  i_sprite_x,
  output vram_addr_t      o_vram_addr,
  output logic            o_vram_wr,
  output logic            o_vram_rd,
  output logic            o_cram_sel,
  output vdp_mode_e       o_mode,
  output vram_addr_t      o_name_table_addr,
  output cpu_byte_t       o_status
);

  cpu_byte_t    vdp_regs [`SMS_VDP_REG_COUNT];
  cpu_byte_t    first_byte;
  logic         second_byte;
  logic         data_rd_q;
  logic         ctrl_rd_q;
  logic         irq_flag;
  logic         collision_flag;
  vdp_reg_idx_t reg_idx;

  assign reg_idx = vdp_reg_idx_t'(i_cpu_dout[3:0]);

  // VRAM strobes last one CPU cycle
  assign o_vram_wr = i_vdp_data_wr && i_cpu_ce;
  assign o_vram_rd = i_vdp_data_rd && i_cpu_ce;

  // ============================================================
  // Address latch, pointer and register writes
  // ============================================================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      for (int i = 0; i < `SMS_VDP_REG_COUNT; i++) begin
        vdp_regs[i] <= '0;
      end
      first_byte  <= '0;
      second_byte <= 1'b0;
      o_vram_addr <= '0;
      o_cram_sel  <= 1'b0;
      data_rd_q   <= 1'b0;
    end else if (i_cpu_ce) begin
      data_rd_q <= i_vdp_data_rd;
      if (i_vdp_data_wr) begin
        o_vram_addr <= o_vram_addr + 1'b1;
      end
      // Read data was fetched from the old address, step once it ends
      if (data_rd_q && !i_vdp_data_rd) begin
        o_vram_addr <= o_vram_addr + 1'b1;
      end

      if (i_vdp_ctrl_rd || i_vdp_data_rd || i_vdp_data_wr) begin
        second_byte <= 1'b0;
      end else if (i_vdp_ctrl_wr) begin
        second_byte <= !second_byte;
        if (!second_byte) begin
          first_byte <= i_cpu_dout;
        end else if (!i_cpu_dout[7]) begin
          // VRAM read or write setup, bit 6 ignored
          o_vram_addr <= {i_cpu_dout[5:0], first_byte};
          o_cram_sel  <= 1'b0;
        end else if (i_cpu_dout[7:6] == 2'b10 && reg_idx < `SMS_VDP_REG_COUNT) begin
          vdp_regs[reg_idx] <= first_byte;
        end else begin
          o_vram_addr <= {8'h00, first_byte[5:0]};
          o_cram_sel  <= 1'b1;
        end
      end
    end
  end

  // ============================================================
  // Sticky status flags
  // ============================================================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      irq_flag       <= 1'b0;
      collision_flag <= 1'b0;
      ctrl_rd_q      <= 1'b0;
    end else begin
      if (i_vdp_irq_flag) begin
        irq_flag <= 1'b1;
      end
      if (i_sprite_collision) begin
        collision_flag <= 1'b1;
      end
      if (i_cpu_ce) begin
        ctrl_rd_q <= i_vdp_ctrl_rd;
        // Cleared when the status read has finished
        if (ctrl_rd_q && !i_vdp_ctrl_rd) begin
          irq_flag       <= 1'b0;
          collision_flag <= 1'b0;
        end
      end
    end
  end

  assign o_status = {irq_flag, i_too_many_sprites, collision_flag,
                     (i_too_many_sprites ? i_sprite_x : 5'b11111)};

  // Highest mode bit wins
  always_comb begin
    if (vdp_regs[0][2]) begin
      o_mode = VDP_MODE_4;
    end else if (vdp_regs[1][3]) begin
      o_mode = VDP_MODE_3;
    end else if (vdp_regs[0][1]) begin
      o_mode = VDP_MODE_2;
    end else if (vdp_regs[1][4]) begin
      o_mode = VDP_MODE_1;
    end else begin
      o_mode = VDP_MODE_0;
    end
  end

  assign o_name_table_addr = {vdp_regs[2][3:1], 11'b0};

  // Decode keeps the two data strobes apart
  a_vram_rd_wr_exclusive : assert property (
    @(posedge cpuClock) disable iff (!n_hard_reset) !(o_vram_wr && o_vram_rd)
  ) else $error("VRAM read and write strobes overlap");

  // Write strobe lasts a single cycle
  a_vram_wr_single_pulse : assert property (
    @(posedge cpuClock) disable iff (!n_hard_reset)
    o_vram_wr |=> !o_vram_wr
  ) else $error("VRAM write strobe longer than one cycle");

endmodule

`default_nettype wire

// File: sms_mem_mapper.sv
`timescale 1ns/1ps
`default_nettype none
`include "sms_defs.svh"

module sms_mem_mapper
  import sms_bus_pkg::*;
(
  input  wire logic      cpuClock,
  input  wire logic      n_hard_reset,
  input  wire logic      i_cpu_ce,
  input  wire cpu_addr_t i_cpu_addr,
  input  wire cpu_byte_t i_cpu_dout,
  input  wire logic      i_mem_ctrl_wr,
  input  wire logic      i_mem_wr,
  output rom_addr_t      o_rom_addr,
  output logic           o_ram_we,
  output logic           o_bios_sel
);

  cpu_byte_t  mem_ctrl;
  cpu_byte_t  slot0;
  cpu_byte_t  slot1;
  cpu_byte_t  slot2;
  cpu_byte_t  page_bank;
  logic [1:0] page;

  assign page = i_cpu_addr[15:14];

  // ============================================================
  // Control and mapper registers
  // ============================================================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      mem_ctrl <= `SMS_MEM_CTRL_RESET;
      slot0    <= `SMS_SLOT0_RESET;
      slot1    <= `SMS_SLOT1_RESET;
      slot2    <= `SMS_SLOT2_RESET;
    end else if (i_cpu_ce) begin
      if (i_mem_ctrl_wr) begin
        mem_ctrl <= i_cpu_dout;
      end
      // The write also lands in RAM underneath
      if (i_mem_wr) begin
        case (i_cpu_addr)
          `SMS_MAP_SLOT0_ADDR: slot0 <= i_cpu_dout;
          `SMS_MAP_SLOT1_ADDR: slot1 <= i_cpu_dout;
          `SMS_MAP_SLOT2_ADDR: slot2 <= i_cpu_dout;
          default: ;
        endcase
      end
    end
  end

  // Bank for the addressed page
  always_comb begin
    case (page)
      2'd0:    page_bank = slot0;
      2'd1:    page_bank = slot1;
      default: page_bank = slot2;
    endcase
  end

  // Page 3 is RAM, passed through unmapped
  assign o_rom_addr = (page == 2'd3) ? {8'h00, i_cpu_addr}
                                     : {2'b00, page_bank, i_cpu_addr[13:0]};

  assign o_ram_we   = i_mem_wr && (page == 2'd3);

  // Bit 3 low enables the BIOS
  assign o_bios_sel = !mem_ctrl[3];

endmodule

`default_nettype wire

// File: sms_read_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "sms_defs.svh"

module sms_read_mux
  import sms_bus_pkg::*;
(
  input  wire io_port_e     i_io_rd_port,
  input  wire logic         i_io_rd_valid,
  input  wire logic         i_mem_rd,
  input  wire logic         i_bios_sel,
  input  wire cpu_addr_t    i_cpu_addr,
  input  wire cpu_byte_t    i_vram_rdata,
  input  wire cpu_byte_t    i_status,
  input  wire cpu_byte_t    i_v_counter,
  input  wire cpu_byte_t    i_h_counter,
  input  wire cpu_byte_t    i_bios_rdata,
  input  wire cpu_byte_t    i_rom_rdata,
  input  wire cpu_byte_t    i_ram_rdata,
  input  wire pad_buttons_t i_buttons,
  output cpu_byte_t         o_cpu_din
);

  cpu_byte_t joy_a;
  cpu_byte_t io_byte;
  logic      io_hit;
  cpu_byte_t mem_byte;

  // Buttons are active high here, the port reads active low
  assign joy_a = {2'b11, ~i_buttons[2:1], ~i_buttons[6:3]};

  // ============================================================
  // I/O read sources
  // ============================================================

  always_comb begin
    io_hit  = i_io_rd_valid;
    io_byte = 8'h00;
    case (i_io_rd_port)
      PORT_VDP_DATA:      io_byte = i_vram_rdata;
      PORT_VDP_CTRL:      io_byte = i_status;
      PORT_JOY_A:         io_byte = joy_a;
      PORT_JOY_B:         io_byte = `SMS_JOY1_IDLE;
      PORT_V_COUNTER:     io_byte = i_v_counter;
      PORT_PSG_H_COUNTER: io_byte = i_h_counter;
      // Control ports have no read value, fall through to memory
      default:            io_hit = 1'b0;
    endcase
  end

  // Pages 0 to 2 come from BIOS or cartridge, page 3 from RAM
  assign mem_byte = (i_mem_rd && i_cpu_addr[15:14] != 2'd3)
                    ? (i_bios_sel ? i_bios_rdata : i_rom_rdata)
                    : i_ram_rdata;

  assign o_cpu_din = io_hit ? io_byte : mem_byte;

endmodule

`default_nettype wire

// File: sms_chipset.sv
`timescale 1ns/1ps
`default_nettype none

module sms_chipset
  import sms_bus_pkg::*;
  import sms_vdp_pkg::*;
(
  input  wire logic         cpuClock,
  input  wire logic         n_hard_reset,
  input  wire logic         i_cpu_ce,
  // Z80 bus
  input  wire cpu_addr_t    i_cpu_addr,
  input  wire cpu_byte_t    i_cpu_dout,
  input  wire logic         i_n_rd,
  input  wire logic         i_n_wr,
  input  wire logic         i_n_mreq,
  input  wire logic         i_n_iorq,
  // Video side
  input  wire cpu_byte_t    i_vram_rdata,
  input  wire logic         i_vdp_irq_flag,
  input  wire logic         i_sprite_collision,
  input  wire logic         i_too_many_sprites,
  input  wire sprite_x_t    i_sprite_x,
  input  wire cpu_byte_t    i_v_counter,
  input  wire cpu_byte_t    i_h_counter,
  // Memory bytes and pads
  input  wire cpu_byte_t    i_bios_rdata,
  input  wire cpu_byte_t    i_rom_rdata,
  input  wire cpu_byte_t    i_ram_rdata,
  input  wire pad_buttons_t i_buttons,
  output cpu_byte_t         o_cpu_din,
  output vram_addr_t        o_vram_addr,
  output logic              o_vram_wr,
  output logic              o_vram_rd,
  output logic              o_cram_sel,
  output vdp_mode_e         o_mode,
  output vram_addr_t        o_name_table_addr,
  output rom_addr_t         o_rom_addr,
  output logic              o_ram_we
);

  io_port_e  io_rd_port;
  logic      io_rd_valid;
  logic      vdp_data_rd;
  logic      vdp_data_wr;
  logic      vdp_ctrl_rd;
  logic      vdp_ctrl_wr;
  logic      mem_ctrl_wr;
  logic      mem_wr;
  logic      mem_rd;
  cpu_byte_t vdp_status;
  logic      bios_sel;

  sms_bus_decode u_bus_decode (
    .i_cpu_addr    (i_cpu_addr),
    .i_n_rd        (i_n_rd),
    .i_n_wr        (i_n_wr),
    .i_n_mreq      (i_n_mreq),
    .i_n_iorq      (i_n_iorq),
    .o_io_rd_port  (io_rd_port),
    .o_io_rd_valid (io_rd_valid),
    .o_vdp_data_rd (vdp_data_rd),
    .o_vdp_data_wr (vdp_data_wr),
    .o_vdp_ctrl_rd (vdp_ctrl_rd),
    .o_vdp_ctrl_wr (vdp_ctrl_wr),
    .o_mem_ctrl_wr (mem_ctrl_wr),
    .o_mem_wr      (mem_wr),
    .o_mem_rd      (mem_rd)
  );

  sms_vdp_port u_vdp_port (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_ce           (i_cpu_ce),
    .i_cpu_dout         (i_cpu_dout),
    .i_vdp_data_rd      (vdp_data_rd),
    .i_vdp_data_wr      (vdp_data_wr),
    .i_vdp_ctrl_rd      (vdp_ctrl_rd),
    .i_vdp_ctrl_wr      (vdp_ctrl_wr),
    .i_vdp_irq_flag     (i_vdp_irq_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_sprite_x         (i_sprite_x),
    .o_vram_addr        (o_vram_addr),
    .o_vram_wr          (o_vram_wr),
    .o_vram_rd          (o_vram_rd),
    .o_cram_sel         (o_cram_sel),
    .o_mode             (o_mode),
    .o_name_table_addr  (o_name_table_addr),
    .o_status           (vdp_status)
  );

  sms_mem_mapper u_mem_mapper (
    .cpuClock      (cpuClock),
    .n_hard_reset  (n_hard_reset),
    .i_cpu_ce      (i_cpu_ce),
    .i_cpu_addr    (i_cpu_addr),
    .i_cpu_dout    (i_cpu_dout),
    .i_mem_ctrl_wr (mem_ctrl_wr),
    .i_mem_wr      (mem_wr),
    .o_rom_addr    (o_rom_addr),
    .o_ram_we      (o_ram_we),
    .o_bios_sel    (bios_sel)
  );

  sms_read_mux u_read_mux (
    .i_io_rd_port  (io_rd_port),
    .i_io_rd_valid (io_rd_valid),
    .i_mem_rd      (mem_rd),
    .i_bios_sel    (bios_sel),
    .i_cpu_addr    (i_cpu_addr),
    .i_vram_rdata  (i_vram_rdata),
    .i_status      (vdp_status),
    .i_v_counter   (i_v_counter),
    .i_h_counter   (i_h_counter),
    .i_bios_rdata  (i_bios_rdata),
    .i_rom_rdata   (i_rom_rdata),
    .i_ram_rdata   (i_ram_rdata),
    .i_buttons     (i_buttons),
    .o_cpu_din     (o_cpu_din)
  );

endmodule

`default_nettype wire

// File: tb_sms_chipset.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sms_chipset
  import sms_bus_pkg::*;
  import sms_vdp_pkg::*;
();

  // Bus operations of a table row
  localparam logic [2:0] OP_NONE   = 3'd0;
  localparam logic [2:0] OP_IO_WR  = 3'd1;
  localparam logic [2:0] OP_IO_RD  = 3'd2;
  localparam logic [2:0] OP_MEM_WR = 3'd3;
  localparam logic [2:0] OP_MEM_RD = 3'd4;
  // Video-side flag inputs, addr bits are irq, collision, too-many
  localparam logic [2:0] OP_FLAGS  = 3'd5;

  // Results checked during the cycle
  localparam logic [3:0] CHK_NONE = 4'd0;
  localparam logic [3:0] CHK_BYTE = 4'd1;
  localparam logic [3:0] CHK_ROM  = 4'd2;
  localparam logic [3:0] CHK_BIOS = 4'd3;
  localparam logic [3:0] CHK_CART = 4'd4;
  localparam logic [3:0] CHK_RAM  = 4'd5;
  localparam logic [3:0] CHK_VRD  = 4'd6;
  localparam logic [3:0] CHK_VC   = 4'd7;
  localparam logic [3:0] CHK_HC   = 4'd8;
  localparam logic [3:0] CHK_JOYA = 4'd9;
  // Results checked once the cycle has ended
  localparam logic [3:0] CHK_VRAM = 4'd10;
  localparam logic [3:0] CHK_NAME = 4'd11;
  localparam logic [3:0] CHK_MODE = 4'd12;
  localparam logic [3:0] CHK_CRAM = 4'd13;

  localparam int CE_TIMEOUT = 16;

  typedef struct packed {
    logic [2:0]  op;
    cpu_addr_t   addr;
    cpu_byte_t   data;
    logic [3:0]  chk;
    logic [23:0] exp;
  } row_t;

  logic         cpuClock;
  logic         n_hard_reset;
  logic         i_cpu_ce;
  cpu_addr_t    i_cpu_addr;
  cpu_byte_t    i_cpu_dout;
  logic         i_n_rd;
  logic         i_n_wr;
  logic         i_n_mreq;
  logic         i_n_iorq;
  cpu_byte_t    i_vram_rdata;
  logic         i_vdp_irq_flag;
  logic         i_sprite_collision;
  logic         i_too_many_sprites;
  sprite_x_t    i_sprite_x;
  cpu_byte_t    i_v_counter;
  cpu_byte_t    i_h_counter;
  cpu_byte_t    i_bios_rdata;
  cpu_byte_t    i_rom_rdata;
  cpu_byte_t    i_ram_rdata;
  pad_buttons_t i_buttons;
  cpu_byte_t    o_cpu_din;
  vram_addr_t   o_vram_addr;
  logic         o_vram_wr;
  logic         o_vram_rd;
  logic         o_cram_sel;
  vdp_mode_e    o_mode;
  vram_addr_t   o_name_table_addr;
  rom_addr_t    o_rom_addr;
  logic         o_ram_we;

  row_t         rows_q [$];
  string        names_q [$];
  integer       seed;
  logic [1:0]   ce_phase;

  sms_chipset dut (.*);

  // ============================================================
  // Clock and CPU clock enable
  // ============================================================

  initial begin
    cpuClock = 1'b0;
    forever #20 cpuClock = ~cpuClock;
  end

  // One enable every fourth cycle
  initial begin
    ce_phase = 2'd0;
    i_cpu_ce = 1'b0;
    forever begin
      @(posedge cpuClock);
      #2;
      i_cpu_ce = (ce_phase == 2'd3);
      ce_phase = ce_phase + 2'd1;
    end
  end

  // ============================================================
  // Failure reporting and compare tasks
  // ============================================================

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %0b actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input cpu_byte_t exp, input cpu_byte_t act);
    if (act !== exp) begin
      $display("Fail %s expected %02h actual %02h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_vram_addr(input string name, input vram_addr_t exp,
                                 input vram_addr_t act);
    if (act !== exp) begin
      $display("Fail %s expected %04h actual %04h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_rom_addr(input string name, input rom_addr_t exp, input rom_addr_t act);
    if (act !== exp) begin
      $display("Fail %s expected %06h actual %06h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mode(input string name, input vdp_mode_e exp, input vdp_mode_e act);
    if (act !== exp) begin
      $display("Fail %s expected mode %0d actual mode %0d", name, exp, act);
      abort_run();
    end
  endtask

  // Returns at a rising edge where the enable is high
  task automatic wait_ce_edge(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(posedge cpuClock);
      cycles++;
    end while (!i_cpu_ce && cycles < CE_TIMEOUT);
    if (!i_cpu_ce) begin
      $display("Timed out waiting for the CPU clock enable in %s", name);
      abort_run();
    end
  endtask

  // Returns at a falling edge inside the enable cycle
  task automatic wait_ce_high(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge cpuClock);
      cycles++;
    end while (!i_cpu_ce && cycles < CE_TIMEOUT);
    if (!i_cpu_ce) begin
      $display("Timed out waiting for the CPU clock enable in %s", name);
      abort_run();
    end
  endtask

  // ============================================================
  // Stimulus table
  // ============================================================

  task automatic add_row(input string name, input logic [2:0] op, input cpu_addr_t addr,
                         input cpu_byte_t data, input logic [3:0] chk, input logic [23:0] exp);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.chk  = chk;
    r.exp  = exp;
    rows_q.push_back(r);
    names_q.push_back(name);
  endtask

  task automatic build_table();
    add_row("reset_rom_page1", OP_MEM_RD, 16'h4000, 8'h00, CHK_ROM, 24'h004000);
    add_row("reset_bios_read", OP_MEM_RD, 16'h0100, 8'h00, CHK_BIOS, 24'h0);
    add_row("slot0_write", OP_MEM_WR, 16'hFFFD, 8'h05, CHK_NONE, 24'h0);
    add_row("slot1_write", OP_MEM_WR, 16'hFFFE, 8'h0A, CHK_NONE, 24'h0);
    add_row("slot2_write", OP_MEM_WR, 16'hFFFF, 8'h3C, CHK_NONE, 24'h0);
    add_row("map_page0", OP_MEM_RD, 16'h0123, 8'h00, CHK_ROM, 24'h014123);
    add_row("map_page1", OP_MEM_RD, 16'h4567, 8'h00, CHK_ROM, 24'h028567);
    add_row("map_page2", OP_MEM_RD, 16'h8ABC, 8'h00, CHK_ROM, 24'h0F0ABC);
    add_row("map_page3", OP_MEM_RD, 16'hC012, 8'h00, CHK_ROM, 24'h00C012);
    add_row("mem_ctrl_write", OP_IO_WR, 16'h003E, 8'h08, CHK_NONE, 24'h0);
    add_row("cart_read", OP_MEM_RD, 16'h0100, 8'h00, CHK_CART, 24'h0);
    add_row("rom_write", OP_MEM_WR, 16'h2000, 8'h77, CHK_NONE, 24'h0);
    add_row("vram_addr_low", OP_IO_WR, 16'h00BF, 8'h34, CHK_NONE, 24'h0);
    add_row("vram_addr_high", OP_IO_WR, 16'h00BF, 8'h12, CHK_VRAM, 24'h1234);
    add_row("vram_write_0", OP_IO_WR, 16'h00BE, 8'hAA, CHK_VRAM, 24'h1235);
    add_row("vram_write_1", OP_IO_WR, 16'h00BE, 8'h55, CHK_VRAM, 24'h1236);
    add_row("vram_read_data", OP_IO_RD, 16'h00BE, 8'h00, CHK_VRD, 24'h0);
    add_row("vram_read_step", OP_NONE, 16'h00BE, 8'h00, CHK_VRAM, 24'h1237);
    add_row("cram_addr_low", OP_IO_WR, 16'h00BF, 8'h05, CHK_NONE, 24'h0);
    add_row("cram_select", OP_IO_WR, 16'h00BF, 8'hC0, CHK_CRAM, 24'h1);
    add_row("cram_addr", OP_NONE, 16'h00BF, 8'h00, CHK_VRAM, 24'h0005);
    add_row("reg0_data", OP_IO_WR, 16'h00BF, 8'h06, CHK_NONE, 24'h0);
    add_row("reg0_mode4", OP_IO_WR, 16'h00BF, 8'h80, CHK_MODE, 24'h4);
    add_row("reg0_clear_data", OP_IO_WR, 16'h00BF, 8'h00, CHK_NONE, 24'h0);
    add_row("reg0_clear", OP_IO_WR, 16'h00BF, 8'h80, CHK_MODE, 24'h0);
    add_row("reg1_data", OP_IO_WR, 16'h00BF, 8'h10, CHK_NONE, 24'h0);
    add_row("reg1_mode1", OP_IO_WR, 16'h00BF, 8'h81, CHK_MODE, 24'h1);
    add_row("reg2_data", OP_IO_WR, 16'h00BF, 8'h0E, CHK_NONE, 24'h0);
    add_row("reg2_name_table", OP_IO_WR, 16'h00BF, 8'h82, CHK_NAME, 24'h3800);
    add_row("flags_pulse", OP_FLAGS, 16'h0003, 8'h00, CHK_NONE, 24'h0);
    add_row("status_sticky", OP_IO_RD, 16'h00BF, 8'h00, CHK_BYTE, 24'hBF);
    add_row("flags_overflow", OP_FLAGS, 16'h0005, 8'h0A, CHK_NONE, 24'h0);
    add_row("status_overflow", OP_IO_RD, 16'h00BF, 8'h00, CHK_BYTE, 24'hCA);
    add_row("status_cleared", OP_IO_RD, 16'h00BF, 8'h00, CHK_BYTE, 24'h4A);
    add_row("flags_idle", OP_FLAGS, 16'h0000, 8'h00, CHK_NONE, 24'h0);
    add_row("status_idle", OP_IO_RD, 16'h00BF, 8'h00, CHK_BYTE, 24'h1F);
    add_row("joypad_a", OP_IO_RD, 16'h00DC, 8'h00, CHK_JOYA, 24'h0);
    add_row("joypad_b", OP_IO_RD, 16'h00DD, 8'h00, CHK_BYTE, 24'hBF);
    add_row("v_counter", OP_IO_RD, 16'h007E, 8'h00, CHK_VC, 24'h0);
    add_row("h_counter", OP_IO_RD, 16'h007F, 8'h00, CHK_HC, 24'h0);
    add_row("ram_read", OP_MEM_RD, 16'hC100, 8'h00, CHK_RAM, 24'h0);
  endtask

  // ============================================================
  // Row execution
  // ============================================================

  function automatic cpu_byte_t random_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // Two ones on top, then inverted buttons 2..1 and 6..3
  function automatic cpu_byte_t joypad_a_byte(input pad_buttons_t b);
    cpu_byte_t v;
    v[7] = 1'b1;
    v[6] = 1'b1;
    v[5] = !b[2];
    v[4] = !b[1];
    v[3] = !b[6];
    v[2] = !b[5];
    v[1] = !b[4];
    v[0] = !b[3];
    return v;
  endfunction

  // VDP data port sits at A7..A6 = 10 with A0 low
  function automatic logic is_vdp_data_port(input cpu_addr_t addr);
    return (addr[7:6] == 2'b10) && !addr[0];
  endfunction

  task automatic refresh_sources();
    cpu_byte_t pad;
    pad          = random_byte();
    i_buttons    = pad[6:0];
    i_bios_rdata = random_byte();
    i_rom_rdata  = random_byte();
    i_ram_rdata  = random_byte();
    i_vram_rdata = random_byte();
    i_v_counter  = random_byte();
    i_h_counter  = random_byte();
  endtask

  task automatic compare_bus_outputs(input row_t r, input string name);
    case (r.chk)
      CHK_BYTE: check_byte(name, r.exp[7:0], o_cpu_din);
      CHK_ROM:  check_rom_addr(name, r.exp, o_rom_addr);
      CHK_BIOS: check_byte(name, i_bios_rdata, o_cpu_din);
      CHK_CART: check_byte(name, i_rom_rdata, o_cpu_din);
      CHK_RAM:  check_byte(name, i_ram_rdata, o_cpu_din);
      CHK_VRD:  check_byte(name, i_vram_rdata, o_cpu_din);
      CHK_VC:   check_byte(name, i_v_counter, o_cpu_din);
      CHK_HC:   check_byte(name, i_h_counter, o_cpu_din);
      CHK_JOYA: check_byte(name, joypad_a_byte(i_buttons), o_cpu_din);
      default: ;
    endcase
  endtask

  // VRAM strobes pulse only in the enable cycle
  task automatic compare_cycle_strobes(input row_t r, input string name, input logic ce_high);
    logic data_port;
    data_port = is_vdp_data_port(r.addr);
    check_bit({name, " vram_wr"}, ce_high && r.op == OP_IO_WR && data_port, o_vram_wr);
    check_bit({name, " vram_rd"}, ce_high && r.op == OP_IO_RD && data_port, o_vram_rd);
    check_bit({name, " ram_we"}, r.op == OP_MEM_WR && r.addr[15:14] == 2'b11, o_ram_we);
  endtask

  task automatic verify_settled_state(input row_t r, input string name);
    case (r.chk)
      CHK_VRAM: check_vram_addr(name, r.exp[13:0], o_vram_addr);
      CHK_NAME: check_vram_addr(name, r.exp[13:0], o_name_table_addr);
      CHK_MODE: check_mode(name, vdp_mode_e'(r.exp[2:0]), o_mode);
      CHK_CRAM: check_bit(name, r.exp[0], o_cram_sel);
      default: ;
    endcase
  endtask

  // Active CPU cycle up to a ce edge, then one idle ce cycle
  task automatic run_row(input row_t r, input string name);
    refresh_sources();
    if (r.op == OP_FLAGS) begin
      i_vdp_irq_flag     = r.addr[0];
      i_sprite_collision = r.addr[1];
      i_too_many_sprites = r.addr[2];
      i_sprite_x         = r.data[4:0];
      wait_ce_edge(name);
      #2;
      i_vdp_irq_flag     = 1'b0;
      i_sprite_collision = 1'b0;
    end else if (r.op != OP_NONE) begin
      i_cpu_addr = r.addr;
      i_cpu_dout = r.data;
      i_n_iorq   = !(r.op == OP_IO_WR || r.op == OP_IO_RD);
      i_n_mreq   = !(r.op == OP_MEM_WR || r.op == OP_MEM_RD);
      i_n_wr     = !(r.op == OP_IO_WR || r.op == OP_MEM_WR);
      i_n_rd     = !(r.op == OP_IO_RD || r.op == OP_MEM_RD);
      #5;
      compare_bus_outputs(r, name);
      compare_cycle_strobes(r, name, 1'b0);
      wait_ce_high(name);
      compare_cycle_strobes(r, name, 1'b1);
      wait_ce_edge(name);
      #2;
      i_n_iorq = 1'b1;
      i_n_mreq = 1'b1;
      i_n_wr   = 1'b1;
      i_n_rd   = 1'b1;
    end
    wait_ce_edge(name);
    #2;
    verify_settled_state(r, name);
  endtask

  initial begin
    seed               = 64;
    n_hard_reset       = 1'b0;
    i_cpu_addr         = '0;
    i_cpu_dout         = '0;
    i_n_rd             = 1'b1;
    i_n_wr             = 1'b1;
    i_n_mreq           = 1'b1;
    i_n_iorq           = 1'b1;
    i_vdp_irq_flag     = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_sprite_x         = '0;
    refresh_sources();
    build_table();

    repeat (2) @(posedge cpuClock);
    #2;
    n_hard_reset = 1'b1;
    wait_ce_edge("reset_release");
    #2;

    for (int i = 0; i < rows_q.size(); i++) begin
      run_row(rows_q[i], names_q[i]);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
sms_bus_pkg.sv
sms_vdp_pkg.sv
sms_bus_decode.sv
sms_vdp_port.sv
sms_mem_mapper.sv
sms_read_mux.sv
sms_chipset.sv
tb_sms_chipset.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_sms_chipset
FILELIST  = verilog.f
BUILD_DIR = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
